/* hdl/iot_filter_cfg.svh */
`ifndef IOT_FILTER_CFG_SVH
`define IOT_FILTER_CFG_SVH

// block framing
`define IOT_BYTES_PER_BLOCK 16
`define IOT_BLOCKS_PER_GROUP 8

// generator x^3+x+1 without its top term
`define IOT_CRC_POLY 3'b011

// axi4-lite bus and register map
`define IOT_AXI_ADDR_W 4
`define IOT_AXI_DATA_W 32
`define IOT_REG_CTRL 4'h0
`define IOT_REG_STATUS 4'h4

`endif

/* hdl/iot_filter_pkg.sv */
`include "iot_filter_cfg.svh"

package iot_filter_pkg;

  typedef logic [7:0] iot_byte_t;
  typedef logic [8*`IOT_BYTES_PER_BLOCK-1:0] iot_block_t;
  typedef logic [2:0] iot_crc_t;
  typedef logic [15:0] iot_count_t;

  // one accepted byte with its block position flags
  typedef struct packed {
    iot_byte_t data;
    logic      first;
    logic      last;
  } iot_beat_t;

  // encoding 3 is idle, bytes are dropped there
  typedef enum logic [1:0] {
    FN_CRC      = 2'd0,
    FN_TOP2MAX  = 2'd1,
    FN_LAST2MIN = 2'd2,
    FN_IDLE     = 2'd3
  } iot_fn_e;

  typedef struct packed {
    logic [`IOT_AXI_ADDR_W-1:0]   awaddr;
    logic                         awvalid;
    logic [`IOT_AXI_DATA_W-1:0]   wdata;
    logic [`IOT_AXI_DATA_W/8-1:0] wstrb;
    logic                         wvalid;
    logic                         bready;
    logic [`IOT_AXI_ADDR_W-1:0]   araddr;
    logic                         arvalid;
    logic                         rready;
  } axil_req_t;

  typedef struct packed {
    logic                       awready;
    logic                       wready;
    logic [1:0]                 bresp;
    logic                       bvalid;
    logic                       arready;
    logic [`IOT_AXI_DATA_W-1:0] rdata;
    logic [1:0]                 rresp;
    logic                       rvalid;
  } axil_rsp_t;

  typedef enum logic [1:0] {
    COLLECT,
    EMIT_FIRST,
    EMIT_SECOND
  } iot_track_state_e;

endpackage

/* hdl/iot_block_loader.sv */
`timescale 1ns/1ps
`include "iot_filter_cfg.svh"

module iot_block_loader (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       i_restart,
  input  logic                       i_accept,
  input  iot_filter_pkg::iot_byte_t  i_byte,
  output iot_filter_pkg::iot_beat_t  o_beat,
  output logic                       o_block_valid,
  output iot_filter_pkg::iot_block_t o_block
);

  localparam int POS_W = $clog2(`IOT_BYTES_PER_BLOCK);
  localparam logic [POS_W-1:0] POS_LAST = POS_W'(`IOT_BYTES_PER_BLOCK - 1);
  localparam int BYTE_W = $bits(iot_filter_pkg::iot_byte_t);
  localparam int BLOCK_W = $bits(iot_filter_pkg::iot_block_t);

  logic [POS_W-1:0] pos_q;
  iot_filter_pkg::iot_block_t shift_q;

  // beat flags follow the current byte position
  assign o_beat.data  = i_byte;
  assign o_beat.first = (pos_q == '0);
  assign o_beat.last  = (pos_q == POS_LAST);
  assign o_block      = shift_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pos_q         <= '0;
      o_block_valid <= 1'b0;
    end else if (i_restart) begin
      pos_q         <= '0;
      o_block_valid <= 1'b0;
    end else begin
      o_block_valid <= i_accept && (pos_q == POS_LAST);
      if (i_accept) begin
        if (pos_q == POS_LAST) begin
          pos_q <= '0;
        end else begin
          pos_q <= pos_q + 1'b1;
        end
      end
    end
  end

  // bytes enter at the bottom so byte 0 ends up as the top byte
  always_ff @(posedge clk) begin
    if (i_accept) begin
      shift_q <= {shift_q[BLOCK_W-BYTE_W-1:0], i_byte};
    end
  end

endmodule

/* hdl/iot_crc3.sv */
`timescale 1ns/1ps
`include "iot_filter_cfg.svh"

module iot_crc3 (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_restart,
  input  logic                      i_beat_valid,
  input  iot_filter_pkg::iot_beat_t i_beat,
  output logic                      o_valid,
  output iot_filter_pkg::iot_crc_t  o_crc,
  input  logic                      i_ready
);

  iot_filter_pkg::iot_crc_t rem_q;
  iot_filter_pkg::iot_crc_t rem_start;
  iot_filter_pkg::iot_crc_t rem_next;

  // eight long-division steps, msb of the byte first
  function automatic iot_filter_pkg::iot_crc_t crc_byte(
    input iot_filter_pkg::iot_crc_t  rem_in,
    input iot_filter_pkg::iot_byte_t data
  );
    iot_filter_pkg::iot_crc_t rem;
    logic fb;
    rem = rem_in;
    for (int i = 7; i >= 0; i--) begin
      fb  = rem[2] ^ data[i];
      rem = {rem[1:0], 1'b0} ^ (fb ? `IOT_CRC_POLY : 3'b000);
    end
    return rem;
  endfunction

  // byte 0 of a block starts from a zero remainder
  assign rem_start = i_beat.first ? '0 : rem_q;
  assign rem_next  = crc_byte(rem_start, i_beat.data);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rem_q   <= '0;
      o_valid <= 1'b0;
    end else if (i_restart) begin
      rem_q   <= '0;
      o_valid <= 1'b0;
    end else begin
      if (i_beat_valid) begin
        rem_q <= rem_next;
      end
      if (i_beat_valid && i_beat.last) begin
        o_valid <= 1'b1;
      end else if (i_ready) begin
        o_valid <= 1'b0;
      end
    end
  end

  // result stays put until the sink takes it
  always_ff @(posedge clk) begin
    if (i_beat_valid && i_beat.last) begin
      o_crc <= rem_next;
    end
  end

endmodule

/* hdl/iot_extreme_tracker.sv */
`timescale 1ns/1ps
`include "iot_filter_cfg.svh"

module iot_extreme_tracker (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       i_restart,
  input  iot_filter_pkg::iot_fn_e    i_fn,
  input  logic                       i_block_valid,
  input  iot_filter_pkg::iot_block_t i_block,
  output logic                       o_valid,
  output iot_filter_pkg::iot_block_t o_result,
  input  logic                       i_ready
);

  localparam int GRP_W = $clog2(`IOT_BLOCKS_PER_GROUP);
  localparam logic [GRP_W-1:0] GRP_LAST = GRP_W'(`IOT_BLOCKS_PER_GROUP - 1);

  iot_filter_pkg::iot_track_state_e state_q;
  logic [GRP_W-1:0] grp_cnt_q;
  iot_filter_pkg::iot_block_t best_q;
  iot_filter_pkg::iot_block_t second_q;
  logic is_max;
  logic beats_best;
  logic beats_second;

  assign is_max = (i_fn == iot_filter_pkg::FN_TOP2MAX);

  // strict compare, ties keep the older block
  assign beats_best   = is_max ? (i_block > best_q) : (i_block < best_q);
  assign beats_second = is_max ? (i_block > second_q) : (i_block < second_q);

  assign o_valid  = (state_q != iot_filter_pkg::COLLECT);
  assign o_result = (state_q == iot_filter_pkg::EMIT_SECOND) ? second_q : best_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q   <= iot_filter_pkg::COLLECT;
      grp_cnt_q <= '0;
    end else if (i_restart) begin
      state_q   <= iot_filter_pkg::COLLECT;
      grp_cnt_q <= '0;
    end else begin
      case (state_q)
        iot_filter_pkg::COLLECT: begin
          if (i_block_valid) begin
            if (grp_cnt_q == GRP_LAST) begin
              grp_cnt_q <= '0;
              state_q   <= iot_filter_pkg::EMIT_FIRST;
            end else begin
              grp_cnt_q <= grp_cnt_q + 1'b1;
            end
          end
        end
        iot_filter_pkg::EMIT_FIRST: begin
          if (i_ready) begin
            state_q <= iot_filter_pkg::EMIT_SECOND;
          end
        end
        iot_filter_pkg::EMIT_SECOND: begin
          if (i_ready) begin
            state_q <= iot_filter_pkg::COLLECT;
          end
        end
        default: state_q <= iot_filter_pkg::COLLECT;
      endcase
    end
  end

  // ranking registers, only touched while collecting
  always_ff @(posedge clk) begin
    if (i_block_valid && (state_q == iot_filter_pkg::COLLECT)) begin
      if (grp_cnt_q == '0) begin
        best_q   <= i_block;
        second_q <= is_max ? '0 : '1;
      end else if (beats_best) begin
        best_q   <= i_block;
        second_q <= best_q;
      end else if (beats_second) begin
        second_q <= i_block;
      end
    end
  end

endmodule

/* hdl/iot_csr.sv */
`timescale 1ns/1ps
`include "iot_filter_cfg.svh"

module iot_csr (
  input  logic                      clk,
  input  logic                      rst,
  input  iot_filter_pkg::axil_req_t i_axil,
  output iot_filter_pkg::axil_rsp_t o_axil,
  input  logic                      i_result_done,
  input  logic                      i_busy,
  output iot_filter_pkg::iot_fn_e   o_fn,
  output logic                      o_restart
);

  localparam int DATA_W = `IOT_AXI_DATA_W;
  localparam logic [1:0] RESP_OKAY = 2'b00;

  iot_filter_pkg::iot_fn_e    fn_q;
  iot_filter_pkg::iot_count_t count_q;
  logic                       bvalid_q;
  logic                       rvalid_q;
  logic [DATA_W-1:0]          rdata_q;
  logic [DATA_W-1:0]          rd_mux;
  logic                       wr_hs;
  logic                       rd_hs;
  logic                       ctrl_wr;

  // address and data are taken together once no response is outstanding
  assign wr_hs = i_axil.awvalid && i_axil.wvalid && !bvalid_q;
  assign rd_hs = i_axil.arvalid && !rvalid_q;

  // fn sits in the low byte lane
  assign ctrl_wr = wr_hs && (i_axil.awaddr == `IOT_REG_CTRL) && i_axil.wstrb[0];

  assign o_restart = ctrl_wr;
  assign o_fn      = fn_q;

  always_comb begin
    o_axil         = '0;
    o_axil.awready = wr_hs;
    o_axil.wready  = wr_hs;
    o_axil.bresp   = RESP_OKAY;
    o_axil.bvalid  = bvalid_q;
    o_axil.arready = rd_hs;
    o_axil.rdata   = rdata_q;
    o_axil.rresp   = RESP_OKAY;
    o_axil.rvalid  = rvalid_q;
  end

  // read decode, unmapped addresses return zero
  always_comb begin
    rd_mux = '0;
    case (i_axil.araddr)
      `IOT_REG_CTRL: begin
        rd_mux[1:0] = fn_q;
      end
      `IOT_REG_STATUS: begin
        rd_mux[15:0] = count_q;
        rd_mux[16]   = i_busy;
      end
      default: begin
        rd_mux = '0;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fn_q     <= iot_filter_pkg::FN_IDLE;
      count_q  <= '0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_hs) begin
        bvalid_q <= 1'b1;
      end else if (i_axil.bready) begin
        bvalid_q <= 1'b0;
      end

      if (rd_hs) begin
        rvalid_q <= 1'b1;
      end else if (i_axil.rready) begin
        rvalid_q <= 1'b0;
      end

      // new function restarts the result count
      if (ctrl_wr) begin
        fn_q    <= iot_filter_pkg::iot_fn_e'(i_axil.wdata[1:0]);
        count_q <= '0;
      end else if (i_result_done) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_hs) begin
      rdata_q <= rd_mux;
    end
  end

endmodule

/* hdl/iot_filter_top.sv */
`timescale 1ns/1ps

module iot_filter_top (
  input  logic                       clk,
  input  logic                       rst,
  input  iot_filter_pkg::axil_req_t  i_axil,
  output iot_filter_pkg::axil_rsp_t  o_axil,
  input  logic                       i_in_en,
  input  iot_filter_pkg::iot_byte_t  i_iot_in,
  output logic                       o_busy,
  output logic                       o_valid,
  output iot_filter_pkg::iot_block_t o_result,
  input  logic                       i_ready
);

  localparam int PAD_W = $bits(iot_filter_pkg::iot_block_t) - $bits(iot_filter_pkg::iot_crc_t);

  iot_filter_pkg::iot_fn_e    fn;
  iot_filter_pkg::iot_beat_t  beat;
  iot_filter_pkg::iot_block_t block;
  iot_filter_pkg::iot_crc_t   crc;
  iot_filter_pkg::iot_block_t trk_result;
  logic restart;
  logic accept;
  logic is_crc;
  logic is_ext;
  logic block_valid;
  logic crc_valid;
  logic trk_valid;
  logic result_done;

  assign is_crc = (fn == iot_filter_pkg::FN_CRC);
  assign is_ext = (fn == iot_filter_pkg::FN_TOP2MAX) || (fn == iot_filter_pkg::FN_LAST2MIN);

  // bytes move only with a function selected and no result waiting
  assign accept = i_in_en && !o_busy && (is_crc || is_ext);

  // result mux, idle never presents anything
  assign o_valid  = (is_crc && crc_valid) || (is_ext && trk_valid);
  assign o_result = is_crc ? {{PAD_W{1'b0}}, crc} : trk_result;
  assign o_busy   = o_valid;

  assign result_done = o_valid && i_ready;

  iot_csr u_csr (
    .clk           (clk),
    .rst           (rst),
    .i_axil        (i_axil),
    .o_axil        (o_axil),
    .i_result_done (result_done),
    .i_busy        (o_busy),
    .o_fn          (fn),
    .o_restart     (restart)
  );

  iot_block_loader u_loader (
    .clk           (clk),
    .rst           (rst),
    .i_restart     (restart),
    .i_accept      (accept),
    .i_byte        (i_iot_in),
    .o_beat        (beat),
    .o_block_valid (block_valid),
    .o_block       (block)
  );

  iot_crc3 u_crc (
    .clk          (clk),
    .rst          (rst),
    .i_restart    (restart),
    .i_beat_valid (accept && is_crc),
    .i_beat       (beat),
    .o_valid      (crc_valid),
    .o_crc        (crc),
    .i_ready      (i_ready && is_crc)
  );

  iot_extreme_tracker u_tracker (
    .clk           (clk),
    .rst           (rst),
    .i_restart     (restart),
    .i_fn          (fn),
    .i_block_valid (block_valid && is_ext),
    .i_block       (block),
    .o_valid       (trk_valid),
    .o_result      (trk_result),
    .i_ready       (i_ready && is_ext)
  );

endmodule

/* verif/iot_filter_tb_model.svh */
`ifndef IOT_FILTER_TB_MODEL_SVH
`define IOT_FILTER_TB_MODEL_SVH

// remainder of block * x^3 divided by x^3+x+1, msb first
function automatic iot_filter_pkg::iot_crc_t crc3_model(input iot_filter_pkg::iot_block_t blk);
  logic [130:0] rem;
  rem = {blk, 3'b000};
  for (int i = 130; i >= 3; i--) begin
    if (rem[i]) begin
      rem[i -: 4] = rem[i -: 4] ^ 4'b1011;
    end
  end
  return rem[2:0];
endfunction

// extreme of the group, then the extreme of the other seven
function automatic void top_two(
  input  iot_filter_pkg::iot_block_t grp [8],
  input  bit                         want_max,
  output iot_filter_pkg::iot_block_t first,
  output iot_filter_pkg::iot_block_t second
);
  int best;
  int next;
  best = 0;
  for (int i = 1; i < 8; i++) begin
    if (want_max ? (grp[i] > grp[best]) : (grp[i] < grp[best])) begin
      best = i;
    end
  end
  next = (best == 0) ? 1 : 0;
  for (int i = 0; i < 8; i++) begin
    if (i != best && (want_max ? (grp[i] > grp[next]) : (grp[i] < grp[next]))) begin
      next = i;
    end
  end
  first  = grp[best];
  second = grp[next];
endfunction

// axi4-lite write, address and data offered together
task automatic axi_write(input logic [`IOT_AXI_ADDR_W-1:0] addr, input logic [31:0] data);
  int n;
  n = 0;
  @(posedge clk);
  axil_req.awaddr  <= addr;
  axil_req.awvalid <= 1'b1;
  axil_req.wdata   <= data;
  axil_req.wstrb   <= '1;
  axil_req.wvalid  <= 1'b1;
  axil_req.bready  <= 1'b1;
  @(negedge clk);
  while (!axil_rsp.awready) begin
    step_or_abort(n, "write address and data never accepted");
  end
  // both ready lines rise in the same cycle
  check_value("wready", 32'd1, 32'(axil_rsp.wready), CHK_REG);
  @(posedge clk);
  // the dut count restarts on this edge
  if (addr == `IOT_REG_CTRL) begin
    hs_at_ctrl = hs_total;
  end
  axil_req.awvalid <= 1'b0;
  axil_req.wvalid  <= 1'b0;
  n = 0;
  @(negedge clk);
  while (!axil_rsp.bvalid) begin
    step_or_abort(n, "write response never came");
  end
  check_value("bresp", 32'd0, 32'(axil_rsp.bresp), CHK_REG);
  @(posedge clk);
  axil_req.bready <= 1'b0;
endtask

task automatic axi_read(input logic [`IOT_AXI_ADDR_W-1:0] addr, output logic [31:0] data);
  int n;
  n = 0;
  @(posedge clk);
  axil_req.araddr  <= addr;
  axil_req.arvalid <= 1'b1;
  axil_req.rready  <= 1'b1;
  @(negedge clk);
  while (!axil_rsp.arready) begin
    step_or_abort(n, "read address never accepted");
  end
  @(posedge clk);
  axil_req.arvalid <= 1'b0;
  n = 0;
  @(negedge clk);
  while (!axil_rsp.rvalid) begin
    step_or_abort(n, "read data never came");
  end
  data = axil_rsp.rdata;
  check_value("rresp", 32'd0, 32'(axil_rsp.rresp), CHK_REG);
  @(posedge clk);
  axil_req.rready <= 1'b0;
endtask

`endif

/* verif/iot_filter_tb.sv */
`timescale 1ns/1ps
`include "iot_filter_cfg.svh"

module iot_filter_tb;

  parameter int unsigned SEED = 32'h311edf9e;
  localparam int TIMEOUT_CYC = 4000;
  localparam int CHK_RST = 0;
  localparam int CHK_BUSY = 1;
  localparam int CHK_HOLD = 2;
  localparam int CHK_RES = 3;
  localparam int CHK_REG = 4;
  localparam int CHK_CNT = 5;

  logic clk;
  logic rst;
  logic i_in_en;
  logic i_ready;
  logic o_busy;
  logic o_valid;
  iot_filter_pkg::iot_byte_t  i_iot_in;
  iot_filter_pkg::iot_block_t o_result;
  iot_filter_pkg::axil_req_t  axil_req;
  iot_filter_pkg::axil_rsp_t  axil_rsp;

  // expected results in arrival order
  iot_filter_pkg::iot_block_t exp_mem [0:255];
  iot_filter_pkg::iot_block_t exp_head;
  iot_filter_pkg::iot_block_t prev_result;
  int exp_wr;
  int exp_rd;
  int hs_total;
  int hs_at_ctrl;
  bit bp_on;
  bit timed_out;
  int pass_cnt [6];
  int fail_cnt [6];

  iot_filter_top dut (
    .clk      (clk),
    .rst      (rst),
    .i_axil   (axil_req),
    .o_axil   (axil_rsp),
    .i_in_en  (i_in_en),
    .i_iot_in (i_iot_in),
    .o_busy   (o_busy),
    .o_valid  (o_valid),
    .o_result (o_result),
    .i_ready  (i_ready)
  );

  `include "iot_filter_tb_model.svh"

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // sink, random low stretches while back-pressure is on
  initial begin : sink
    int stretch;
    stretch = 0;
    i_ready <= 1'b0;
    forever begin
      @(posedge clk);
      if (!bp_on) begin
        i_ready <= 1'b1;
      end else if (stretch == 0) begin
        i_ready <= !i_ready;
        stretch = $urandom_range(1, 6);
      end else begin
        stretch--;
      end
    end
  end

  always @(posedge clk) begin
    prev_result <= o_result;
    if (rst) begin
      exp_rd   <= 0;
      hs_total <= 0;
    end else if (o_valid && i_ready) begin
      exp_rd   <= exp_rd + 1;
      hs_total <= hs_total + 1;
    end
  end

  // a stuck wait ends the run on the next rising edge
  always @(posedge clk) begin
    if (timed_out) begin
      $display("Testbench failed");
      $finish;
    end
  end

  assign exp_head = exp_mem[exp_rd[7:0]];

  assert property (@(posedge clk)
      rst |-> !o_valid && !o_busy && !axil_rsp.bvalid && !axil_rsp.rvalid)
    pass_cnt[CHK_RST]++;
  else begin
    fail_cnt[CHK_RST]++;
    $display("[FAIL] %0t o_valid/o_busy/bvalid/rvalid expected 0000 actual %b%b%b%b", $time,
      $sampled(o_valid), $sampled(o_busy), $sampled(axil_rsp.bvalid),
      $sampled(axil_rsp.rvalid));
  end

  assert property (@(posedge clk) disable iff (rst) o_valid |-> o_busy)
    pass_cnt[CHK_BUSY]++;
  else begin
    fail_cnt[CHK_BUSY]++;
    $display("[FAIL] %0t o_busy expected 1 actual 0", $time);
  end

  // a stalled result must not move or vanish
  assert property (@(posedge clk) disable iff (rst)
      (o_valid && !i_ready) |=> (o_valid && o_busy && o_result == prev_result))
    pass_cnt[CHK_HOLD]++;
  else begin
    fail_cnt[CHK_HOLD]++;
    $display("[FAIL] %0t o_result expected %h actual %h (valid %b busy %b)", $time,
      $sampled(prev_result), $sampled(o_result), $sampled(o_valid), $sampled(o_busy));
  end

  assert property (@(posedge clk) disable iff (rst)
      (o_valid && i_ready) |-> (exp_rd != exp_wr) && (o_result == exp_head))
    pass_cnt[CHK_RES]++;
  else begin
    fail_cnt[CHK_RES]++;
    if ($sampled(exp_rd) == $sampled(exp_wr)) begin
      $display("%0t: a result was handed over when none was expected", $time);
    end else begin
      $display("[FAIL] %0t o_result expected %h actual %h", $time,
        $sampled(exp_head), $sampled(o_result));
    end
  end

  task automatic step_or_abort(inout int n, input string what);
    if (n == TIMEOUT_CYC) begin
      timed_out = 1'b1;
      $display("timeout at %0t: %s", $time, what);
    end
    n++;
    @(negedge clk);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
      input logic [31:0] actual, input int chk);
    assert (actual === expected) begin
      pass_cnt[chk]++;
    end else begin
      fail_cnt[chk]++;
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  function automatic int failures();
    int sum;
    sum = 0;
    foreach (fail_cnt[i]) begin
      sum += fail_cnt[i];
    end
    return sum;
  endfunction

  function automatic iot_filter_pkg::iot_block_t rand_block();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  task automatic push_expected(input iot_filter_pkg::iot_block_t value);
    exp_mem[exp_wr[7:0]] = value;
    exp_wr++;
  endtask

  // offered byte goes in at the next rising edge once o_busy is low
  task automatic wait_accept();
    int n;
    n = 0;
    @(negedge clk);
    while (o_busy) begin
      step_or_abort(n, "byte never accepted");
    end
    @(posedge clk);
  endtask

  task automatic send_block(input iot_filter_pkg::iot_block_t blk);
    for (int i = 15; i >= 0; i--) begin
      i_in_en  <= 1'b1;
      i_iot_in <= blk[8*i +: 8];
      wait_accept();
    end
  endtask

  task automatic drain_results();
    int n;
    n = 0;
    @(negedge clk);
    while (exp_rd != exp_wr || o_valid) begin
      step_or_abort(n, "expected results never reached the output");
    end
  endtask

  task automatic run_crc(input int n_blocks);
    iot_filter_pkg::iot_block_t blk;
    @(posedge clk);
    for (int b = 0; b < n_blocks; b++) begin
      blk = rand_block();
      push_expected({125'b0, crc3_model(blk)});
      send_block(blk);
    end
    i_in_en <= 1'b0;
    drain_results();
  endtask

  task automatic run_groups(input bit want_max, input int n_groups);
    iot_filter_pkg::iot_block_t grp [8];
    iot_filter_pkg::iot_block_t first;
    iot_filter_pkg::iot_block_t second;
    int k;
    @(posedge clk);
    for (int g = 0; g < n_groups; g++) begin
      foreach (grp[i]) begin
        grp[i] = rand_block();
      end
      // first group carries its extreme twice
      if (g == 0) begin
        top_two(grp, want_max, first, second);
        k = $urandom_range(0, 7);
        while (grp[k] == first) begin
          k = (k + 1) % 8;
        end
        grp[k] = first;
      end
      top_two(grp, want_max, first, second);
      push_expected(first);
      push_expected(second);
      foreach (grp[i]) begin
        send_block(grp[i]);
      end
    end
    i_in_en <= 1'b0;
    drain_results();
  endtask

  // status holds busy low and the handshakes since the last ctrl write
  task automatic check_count();
    logic [31:0] rd;
    axi_read(`IOT_REG_STATUS, rd);
    check_value("status", 32'(hs_total - hs_at_ctrl) & 32'hffff, rd, CHK_CNT);
  endtask

  task automatic report_test(input string name);
    $display("test %s done, %0d results so far, %0d failures", name, exp_rd, failures());
  endtask

  initial begin : main
    logic [31:0] rd;
    void'($urandom(SEED));
    rst        = 1'b1;
    i_in_en    = 1'b0;
    i_iot_in   = '0;
    axil_req   = '0;
    exp_wr     = 0;
    hs_at_ctrl = 0;
    bp_on      = 1'b0;
    timed_out  = 1'b0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("o_valid", 32'd0, 32'(o_valid), CHK_REG);
    check_value("o_busy", 32'd0, 32'(o_busy), CHK_REG);
    axi_read(`IOT_REG_CTRL, rd);
    check_value("ctrl", 32'd3, rd, CHK_REG);
    axi_write(`IOT_REG_CTRL, 32'(iot_filter_pkg::FN_TOP2MAX));
    axi_read(`IOT_REG_CTRL, rd);
    check_value("ctrl", 32'(iot_filter_pkg::FN_TOP2MAX), rd, CHK_REG);
    check_count();
    report_test("registers");
    axi_write(`IOT_REG_CTRL, 32'(iot_filter_pkg::FN_CRC));
    run_crc(6);
    check_count();
    report_test("crc");
    axi_write(`IOT_REG_CTRL, 32'(iot_filter_pkg::FN_TOP2MAX));
    run_groups(1'b1, 2);
    check_count();
    report_test("top2max");
    axi_write(`IOT_REG_CTRL, 32'(iot_filter_pkg::FN_LAST2MIN));
    run_groups(1'b0, 2);
    check_count();
    report_test("last2min");
    bp_on = 1'b1;
    axi_write(`IOT_REG_CTRL, 32'(iot_filter_pkg::FN_CRC));
    run_crc(4);
    check_count();
    axi_write(`IOT_REG_CTRL, 32'(iot_filter_pkg::FN_TOP2MAX));
    run_groups(1'b1, 1);
    check_count();
    bp_on = 1'b0;
    report_test("backpressure");
    $display(
      "pass/fail rst %0d/%0d busy %0d/%0d hold %0d/%0d res %0d/%0d reg %0d/%0d cnt %0d/%0d",
      pass_cnt[CHK_RST], fail_cnt[CHK_RST], pass_cnt[CHK_BUSY], fail_cnt[CHK_BUSY],
      pass_cnt[CHK_HOLD], fail_cnt[CHK_HOLD], pass_cnt[CHK_RES], fail_cnt[CHK_RES],
      pass_cnt[CHK_REG], fail_cnt[CHK_REG], pass_cnt[CHK_CNT], fail_cnt[CHK_CNT]);
    if (failures() == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* iot_filter.f */
+incdir+hdl
+incdir+verif
hdl/iot_filter_pkg.sv
hdl/iot_block_loader.sv
hdl/iot_crc3.sv
hdl/iot_extreme_tracker.sv
hdl/iot_csr.sv
hdl/iot_filter_top.sv
verif/iot_filter_tb.sv

/* Makefile */
# Verilator build and run for the IoT data filter

VERILATOR ?= verilator
TOP       ?= iot_filter_tb
SEED      ?= 824106910
FILELIST  ?= iot_filter.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  := Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# success only when the pass line shows up in the output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
